/* video_defs.svh */
// Fixed coefficients, chroma offset, skin window and pipeline depth, included by the video RTL
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// ---------------------------------------------------------------------------
// Colour conversion, Q8 fixed point, all sums kept to 16 bits
// ---------------------------------------------------------------------------

// Y = (77R + 150G + 29B) >> 8
`define Y_COEF_R		16'd77
`define Y_COEF_G		16'd150
`define Y_COEF_B		16'd29

// Cb = (128B - 43R - 85G + offset) >> 8
`define CB_COEF_R		16'd43
`define CB_COEF_G		16'd85
`define CB_COEF_B		16'd128

// Cr = (128R - 107G - 21B + offset) >> 8
`define CR_COEF_R		16'd128
`define CR_COEF_G		16'd107
`define CR_COEF_B		16'd21

`define CHROMA_OFFSET	16'd32768	// 128 << 8, recentres chroma

// Skin window on chroma, bounds inclusive
`define SKIN_CB_MIN		8'd77
`define SKIN_CB_MAX		8'd127
`define SKIN_CR_MIN		8'd133
`define SKIN_CR_MAX		8'd173

`define CONV_DEPTH		3			// Converter latency in clocks

`endif

/* video_pkg.sv */
// Pixel, sync and view-mode types for the colour path, imported by each block that needs them
`default_nettype none

package video_pkg;

	// -------------------------------------------------------------------------
	// Pixel formats, 8 bits per channel
	// -------------------------------------------------------------------------

	typedef struct packed {
		logic [7:0] red;	// R channel, MSB first on the bus
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;				// RGB888, 24 bits

	typedef struct packed {
		logic [7:0] y;		// Luma
		logic [7:0] cb;		// Blue difference, 128 centred
		logic [7:0] cr;		// Red difference, 128 centred
	} ycbcr_t;				// YCbCr444, 24 bits

	// Frame and line strobes, levels that travel with their pixel
	typedef struct packed {
		logic vsync;		// Frame strobe
		logic href;			// Line active, pixel valid
	} sync_t;

	// Per-pixel output view
	typedef enum logic [1:0] {
		view_ycbcr = 2'd0,	// Y, Cb, Cr on the R, G, B lanes
		view_rgb   = 2'd1,	// Source pixel unchanged
		view_skin  = 2'd2	// Chroma window mask
	} view_t;				// Code 3 falls back to YCbCr

	// Side-path payload, source pixel plus its view
	typedef struct packed {
		rgb_t  pix;
		view_t mode;
	} pix_tag_t;			// 26 bits

endpackage

`default_nettype wire

/* video_delay.sv */
// Fixed-depth register chain for any packed payload, keeps strobes and side data in step
`timescale 1ns/1ps
`default_nettype none

module video_delay #(
	parameter type payload_t = logic [7:0],	// Carried payload, any packed type
	parameter int  DEPTH     = 3			// Number of register stages, at least 1
) (
	input  wire      clk,		// Pixel clock
	input  wire      rst_n,		// Async reset, active low
	input  wire      payload_t d,	// Payload in
	output payload_t q			// Payload out, DEPTH clocks later
);

	// -------------------------------------------------------------------------
	// Shift chain, stage 0 takes d
	// -------------------------------------------------------------------------

	payload_t stage_q [DEPTH];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			// Whole chain clears so nothing stale leaks out after reset
			for (int i = 0; i < DEPTH; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= d;			// Load
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1];	// Shift by one each clock
		end
	end

	assign q = stage_q[DEPTH-1];		// Oldest stage

endmodule

`default_nettype wire

/* rgb_to_ycbcr.sv */
// RGB888 to YCbCr444 converter, three registered stages of multiply, sum and byte select
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module rgb_to_ycbcr (
	input  wire              clk,		// Pixel clock
	input  wire              rst_n,		// Async reset, active low
	input  wire video_pkg::rgb_t  in_pix,	// Source pixel
	input  wire video_pkg::sync_t in_sync,	// Source strobes
	output video_pkg::ycbcr_t     out_pix,	// Converted pixel, 3 clocks later
	output video_pkg::sync_t      out_sync	// Strobes matched to out_pix
);
	import video_pkg::*;

	// -------------------------------------------------------------------------
	// Stage 1, nine constant products
	// -------------------------------------------------------------------------

	logic [15:0] y_r_q;
	logic [15:0] y_g_q;
	logic [15:0] y_b_q;
	logic [15:0] cb_r_q;
	logic [15:0] cb_g_q;
	logic [15:0] cb_b_q;
	logic [15:0] cr_r_q;
	logic [15:0] cr_g_q;
	logic [15:0] cr_b_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			y_r_q  <= '0;
			y_g_q  <= '0;
			y_b_q  <= '0;
			cb_r_q <= '0;
			cb_g_q <= '0;
			cb_b_q <= '0;
			cr_r_q <= '0;
			cr_g_q <= '0;
			cr_b_q <= '0;
		end
		else
		begin
			y_r_q  <= in_pix.red   * `Y_COEF_R;	// Max 255*150 fits 16 bits
			y_g_q  <= in_pix.green * `Y_COEF_G;
			y_b_q  <= in_pix.blue  * `Y_COEF_B;
			cb_r_q <= in_pix.red   * `CB_COEF_R;
			cb_g_q <= in_pix.green * `CB_COEF_G;
			cb_b_q <= in_pix.blue  * `CB_COEF_B;
			cr_r_q <= in_pix.red   * `CR_COEF_R;
			cr_g_q <= in_pix.green * `CR_COEF_G;
			cr_b_q <= in_pix.blue  * `CR_COEF_B;
		end
	end

	// -------------------------------------------------------------------------
	// Stage 2, signed combination plus offset, wraps modulo 2^16
	// -------------------------------------------------------------------------

	logic [15:0] y_sum_q;
	logic [15:0] cb_sum_q;
	logic [15:0] cr_sum_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			y_sum_q  <= '0;
			cb_sum_q <= '0;
			cr_sum_q <= '0;
		end
		else
		begin
			y_sum_q  <= y_r_q + y_g_q + y_b_q;	// Weights add to 256, no overflow
			cb_sum_q <= cb_b_q - cb_r_q - cb_g_q + `CHROMA_OFFSET;
			cr_sum_q <= cr_r_q - cr_g_q - cr_b_q + `CHROMA_OFFSET;
		end
	end

	// -------------------------------------------------------------------------
	// Stage 3, keep the upper byte of each sum
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			out_pix <= '0;
		else
			out_pix <= '{y: y_sum_q[15:8], cb: cb_sum_q[15:8], cr: cr_sum_q[15:8]};
	end

	// Strobes ride alongside the three data stages, no blanking here
	video_delay #(
		.payload_t	(sync_t),
		.DEPTH		(`CONV_DEPTH)
	) sync_dly_i (
		.clk	(clk),
		.rst_n	(rst_n),
		.d		(in_sync),
		.q		(out_sync)
	);

endmodule

`default_nettype wire

/* view_combiner.sv */
// Output stage, classifies skin from chroma, picks the per-pixel view and blanks outside href
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module view_combiner (
	input  wire              clk,		// Pixel clock
	input  wire              rst_n,		// Async reset, active low
	input  wire video_pkg::ycbcr_t conv_pix,	// From the converter
	input  wire video_pkg::sync_t  conv_sync,	// Strobes aligned with conv_pix
	input  wire video_pkg::pix_tag_t tag,		// Delayed source pixel and view
	output video_pkg::rgb_t        out_pix,		// Registered view
	output video_pkg::sync_t       out_sync		// Registered strobes
);
	import video_pkg::*;

	// -------------------------------------------------------------------------
	// Skin classification on Cb and Cr
	// -------------------------------------------------------------------------

	logic cb_in_win;
	logic cr_in_win;
	logic skin_hit;

	assign cb_in_win = (conv_pix.cb >= `SKIN_CB_MIN) && (conv_pix.cb <= `SKIN_CB_MAX);
	assign cr_in_win = (conv_pix.cr >= `SKIN_CR_MIN) && (conv_pix.cr <= `SKIN_CR_MAX);
	assign skin_hit  = cb_in_win && cr_in_win;	// Both inside the window

	// -------------------------------------------------------------------------
	// Candidate views
	// -------------------------------------------------------------------------

	rgb_t ycc_view;
	rgb_t mask_view;
	rgb_t sel_pix;

	// Y, Cb, Cr land on the R, G, B lanes
	assign ycc_view  = '{red: conv_pix.y, green: conv_pix.cb, blue: conv_pix.cr};
	assign mask_view = {24{skin_hit}};		// All 255 or all 0

	always_comb
	begin
		case (tag.mode)
			view_rgb:  sel_pix = tag.pix;	// Source pixel, same age as conv_pix
			view_skin: sel_pix = mask_view;
			default:   sel_pix = ycc_view;	// YCbCr and the spare code 3
		endcase
	end

	// -------------------------------------------------------------------------
	// Output register, the only place pixels are blanked
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_sync <= '0;
			out_pix  <= '0;
		end
		else
		begin
			out_sync <= conv_sync;
			out_pix  <= conv_sync.href ? sel_pix : '0;	// Zero between lines
		end
	end

endmodule

`default_nettype wire

/* video_color_top.sv */
// Colour processing top, wires the converter, the side delay line and the view combiner
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module video_color_top (
	input  wire              clk,		// Pixel clock
	input  wire              rst_n,		// Async reset, active low
	input  wire video_pkg::sync_t in_sync,	// vsync and href in
	input  wire video_pkg::rgb_t  in_pix,	// RGB888 in
	input  wire video_pkg::view_t view,		// View for this pixel
	output video_pkg::sync_t      out_sync,	// Strobes, 4 clocks later
	output video_pkg::rgb_t       out_pix	// Selected view, 4 clocks later
);
	import video_pkg::*;

	// -------------------------------------------------------------------------
	// Internal nets
	// -------------------------------------------------------------------------

	ycbcr_t   conv_pix;		// Converter result
	sync_t    conv_sync;	// Strobes at converter output
	pix_tag_t tag_in;		// Source pixel with its view
	pix_tag_t tag_d;		// Same, aligned with conv_pix

	assign tag_in = '{pix: in_pix, mode: view};

	// Main path, 3 clocks
	rgb_to_ycbcr conv_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.in_pix		(in_pix),
		.in_sync	(in_sync),
		.out_pix	(conv_pix),
		.out_sync	(conv_sync)
	);

	// Side path, matched to the converter depth
	video_delay #(
		.payload_t	(pix_tag_t),
		.DEPTH		(`CONV_DEPTH)
	) tag_dly_i (
		.clk	(clk),
		.rst_n	(rst_n),
		.d		(tag_in),
		.q		(tag_d)
	);

	// Final select and blanking, 1 clock
	view_combiner comb_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.conv_pix	(conv_pix),
		.conv_sync	(conv_sync),
		.tag		(tag_d),
		.out_pix	(out_pix),
		.out_sync	(out_sync)
	);

endmodule

`default_nettype wire

/* video_color_checker.sv */
// Concurrent checks bound into the colour top, each output recomputed from the inputs four clocks back
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module video_color_checker (
	input wire              clk,		// Pixel clock of the bound top
	input wire              rst_n,		// Async reset, active low
	input wire video_pkg::sync_t in_sync,
	input wire video_pkg::rgb_t  in_pix,
	input wire video_pkg::view_t view,
	input wire video_pkg::sync_t out_sync,
	input wire video_pkg::rgb_t  out_pix
);
	import video_pkg::*;

	int unsigned fail_count = 0;	// Failed checks so far, watched by the testbench

	// -------------------------------------------------------------------------
	// Input history, entry 3 holds the input behind the current output
	// -------------------------------------------------------------------------

	sync_t      sync_h [4];
	rgb_t       pix_h  [4];
	view_t      view_h [4];
	logic [2:0] warm;		// Clocks since reset release, saturates at 4

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			warm <= '0;
			for (int i = 0; i < 4; i++)
			begin
				sync_h[i] <= '0;
				pix_h[i]  <= '0;
				view_h[i] <= view_ycbcr;
			end
		end
		else
		begin
			if (warm != 3'd4)
				warm <= warm + 3'd1;
			sync_h[0] <= in_sync;
			pix_h[0]  <= in_pix;
			view_h[0] <= view;
			for (int i = 1; i < 4; i++)
			begin
				sync_h[i] <= sync_h[i-1];
				pix_h[i]  <= pix_h[i-1];
				view_h[i] <= view_h[i-1];
			end
		end
	end

	// YCbCr of a pixel, sums taken modulo 2^16, upper byte kept
	function automatic rgb_t ycc_of(input rgb_t p);
		int r;
		int g;
		int b;
		int y_sum;
		int cb_sum;
		int cr_sum;
		r = int'(p.red);
		g = int'(p.green);
		b = int'(p.blue);
		y_sum  = int'(`Y_COEF_R) * r + int'(`Y_COEF_G) * g + int'(`Y_COEF_B) * b;
		cb_sum = int'(`CB_COEF_B) * b - int'(`CB_COEF_R) * r - int'(`CB_COEF_G) * g
			+ int'(`CHROMA_OFFSET);
		cr_sum = int'(`CR_COEF_R) * r - int'(`CR_COEF_G) * g - int'(`CR_COEF_B) * b
			+ int'(`CHROMA_OFFSET);
		ycc_of = {y_sum[15:8], cb_sum[15:8], cr_sum[15:8]};	// Y, Cb, Cr on R, G, B lanes
	endfunction

	rgb_t exp_ycc;
	rgb_t exp_mask;
	logic live;		// Past the reset shadow and the pixel was inside href

	assign exp_ycc  = ycc_of(pix_h[3]);
	assign exp_mask = ((exp_ycc.green >= `SKIN_CB_MIN) && (exp_ycc.green <= `SKIN_CB_MAX)
		&& (exp_ycc.blue >= `SKIN_CR_MIN) && (exp_ycc.blue <= `SKIN_CR_MAX)) ? 24'hff_ffff : '0;
	assign live     = (warm == 3'd4) && sync_h[3].href;

	// -------------------------------------------------------------------------
	// Output checks
	// -------------------------------------------------------------------------

	a_reset_quiet: assert property (@(posedge clk)
		(!rst_n || warm != 3'd4) |-> (out_sync == '0 && out_pix == '0))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_sync = %b, out_pix = %h, expected 00 and 000000",
				$time, out_sync, out_pix);
		end

	a_sync_delay: assert property (@(posedge clk) disable iff (!rst_n)
		(warm == 3'd4) |-> (out_sync == sync_h[3]))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_sync = %b, expected %b", $time, out_sync, sync_h[3]);
		end

	// Spare code 3 counts as YCbCr
	a_ycc_view: assert property (@(posedge clk) disable iff (!rst_n)
		(live && view_h[3] != view_rgb && view_h[3] != view_skin) |-> (out_pix == exp_ycc))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_pix = %h, expected %h", $time, out_pix, exp_ycc);
		end

	a_rgb_view: assert property (@(posedge clk) disable iff (!rst_n)
		(live && view_h[3] == view_rgb) |-> (out_pix == pix_h[3]))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_pix = %h, expected %h", $time, out_pix, pix_h[3]);
		end

	a_skin_view: assert property (@(posedge clk) disable iff (!rst_n)
		(live && view_h[3] == view_skin) |-> (out_pix == exp_mask))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_pix = %h, expected %h", $time, out_pix, exp_mask);
		end

	a_blanking: assert property (@(posedge clk) !out_sync.href |-> (out_pix == '0))
		else
		begin
			fail_count++;
			$error("Fail at %0t: out_pix = %h, expected 000000 outside href", $time, out_pix);
		end

endmodule

`default_nettype wire

/* tb_video_color.sv */
// Testbench for the colour path top, drives small framed streams and stops on the first checker error
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module tb_video_color;
	import video_pkg::*;

	localparam int SEARCH_LIMIT = 1_000_000;	// Random draws per chroma target
	localparam int DRAIN_LIMIT  = 32;			// Clocks allowed for the pipe to empty

	logic  clk;
	logic  rst_n;
	sync_t in_sync;
	rgb_t  in_pix;
	view_t view;
	sync_t out_sync;
	rgb_t  out_pix;

	rgb_t  directed_q [$];	// Primaries, black, white and skin window edges

	video_color_top dut_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.in_sync	(in_sync),
		.in_pix		(in_pix),
		.view		(view),
		.out_sync	(out_sync),
		.out_pix	(out_pix)
	);

	// Assertions live inside the DUT scope
	bind video_color_top video_color_checker chk_i (
		.clk		(clk),
		.rst_n		(rst_n),
		.in_sync	(in_sync),
		.in_pix		(in_pix),
		.view		(view),
		.out_sync	(out_sync),
		.out_pix	(out_pix)
	);

	// -------------------------------------------------------------------------
	// Clock and reset
	// -------------------------------------------------------------------------

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;		// Released off the edge like the data
	end

	task automatic abort_run(input string why);
		$display("Error at %0t: %s", $time, why);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped on error");
	endtask

	// First checker error ends the run
	always @(negedge clk)
		if (dut_i.chk_i.fail_count != 0)
			abort_run("checker reported an assertion failure");

	// -------------------------------------------------------------------------
	// Stimulus helpers
	// -------------------------------------------------------------------------

	function automatic rgb_t random_pixel();
		random_pixel = 24'($urandom());
	endfunction

	function automatic view_t random_view();
		random_view = view_t'(2'($urandom_range(3)));	// Includes the spare code
	endfunction

	// Cb and Cr of a pixel by the fixed-point rules, packed as {cb, cr}
	function automatic logic [15:0] chroma_of(input rgb_t p);
		int r;
		int g;
		int b;
		int cb_sum;
		int cr_sum;
		r = int'(p.red);
		g = int'(p.green);
		b = int'(p.blue);
		cb_sum = 128 * b - 43 * r - 85 * g + 32768;
		cr_sum = 128 * r - 107 * g - 21 * b + 32768;
		chroma_of = {cb_sum[15:8], cr_sum[15:8]};
	endfunction

	// Random search for a pixel whose chroma falls in the given box
	task automatic add_chroma_pixel(input int cb_lo, input int cb_hi,
		input int cr_lo, input int cr_hi);
		rgb_t        cand;
		logic [15:0] ch;
		bit          hit;
		hit = 1'b0;
		for (int i = 0; i < SEARCH_LIMIT && !hit; i++)
		begin
			cand = random_pixel();
			ch   = chroma_of(cand);
			hit  = int'(ch[15:8]) >= cb_lo && int'(ch[15:8]) <= cb_hi
				&& int'(ch[7:0]) >= cr_lo && int'(ch[7:0]) <= cr_hi;
		end
		if (!hit)
			abort_run($sformatf("no pixel found with Cb %0d..%0d and Cr %0d..%0d",
				cb_lo, cb_hi, cr_lo, cr_hi));
		else
			directed_q.push_back(cand);
	endtask

	task automatic drive_pixel(input logic vs, input logic hr, input rgb_t p, input view_t v);
		@(posedge clk);
		#1;
		in_sync.vsync = vs;
		in_sync.href  = hr;
		in_pix        = p;
		view          = v;
	endtask

	// Blanking cycles carry junk pixels and views that must not leak
	task automatic send_blank(input int n, input logic vs);
		for (int i = 0; i < n; i++)
			drive_pixel(vs, 1'b0, random_pixel(), random_view());
	endtask

	task automatic start_frame();
		send_blank(2, 1'b1);	// vsync pulse
		send_blank(3, 1'b0);	// Back porch
	endtask

	task automatic send_random_line(input int width, input view_t line_view, input bit per_pixel);
		for (int i = 0; i < width; i++)
			drive_pixel(1'b0, 1'b1, random_pixel(), per_pixel ? random_view() : line_view);
		send_blank(3, 1'b0);	// Line gap
	endtask

	task automatic send_directed_line(input view_t v);
		foreach (directed_q[i])
			drive_pixel(1'b0, 1'b1, directed_q[i], v);
		send_blank(3, 1'b0);
	endtask

	// Live strobes and pixels while reset is held, none of it may reach the outputs
	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < 10)
		begin
			drive_pixel(1'b1, 1'b1, random_pixel(), random_view());
			@(negedge clk);
			n++;
		end
		if (rst_n !== 1'b1)
			abort_run("reset was not released in time");
	endtask

	// Frame end, outputs back to idle once the last line has left the pipe
	task automatic wait_frame_drain();
		int n;
		bit idle;
		n    = 0;
		idle = 1'b0;
		while (!idle && n < DRAIN_LIMIT)
		begin
			@(negedge clk);
			idle = (out_sync == '0) && (out_pix == '0);
			n++;
		end
		if (!idle)
			abort_run("output strobes still active long after the frame ended");
	endtask

	task automatic finish_run();
		if (dut_i.chk_i.fail_count != 0)
			abort_run("checker reported an assertion failure");
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	endtask

	// -------------------------------------------------------------------------
	// Main sequence
	// -------------------------------------------------------------------------

	initial
	begin
		in_sync = '0;
		in_pix  = '0;
		view    = view_ycbcr;
		void'($urandom(32'h34e9_26b9));

		directed_q = '{24'h00_0000, 24'hff_ffff, 24'hff_0000, 24'h00_ff00, 24'h00_00ff};
		// Each window edge, once just inside and once just outside
		add_chroma_pixel(int'(`SKIN_CB_MIN), int'(`SKIN_CB_MIN), 145, 160);
		add_chroma_pixel(int'(`SKIN_CB_MIN) - 1, int'(`SKIN_CB_MIN) - 1, 145, 160);
		add_chroma_pixel(int'(`SKIN_CB_MAX), int'(`SKIN_CB_MAX), 145, 160);
		add_chroma_pixel(int'(`SKIN_CB_MAX) + 1, int'(`SKIN_CB_MAX) + 1, 145, 160);
		add_chroma_pixel(90, 115, int'(`SKIN_CR_MIN), int'(`SKIN_CR_MIN));
		add_chroma_pixel(90, 115, int'(`SKIN_CR_MIN) - 1, int'(`SKIN_CR_MIN) - 1);
		add_chroma_pixel(90, 115, int'(`SKIN_CR_MAX), int'(`SKIN_CR_MAX));
		add_chroma_pixel(90, 115, int'(`SKIN_CR_MAX) + 1, int'(`SKIN_CR_MAX) + 1);

		wait_reset_release();

		// Frame 1, one view per line, spare code on line 3
		start_frame();
		for (int ln = 0; ln < 6; ln++)
			send_random_line(10, view_t'(2'(ln % 4)), 1'b0);
		wait_frame_drain();

		// Frame 2, directed pixels through every view
		start_frame();
		send_directed_line(view_skin);
		send_directed_line(view_ycbcr);
		send_directed_line(view_rgb);
		wait_frame_drain();

		// Frame 3, view changes pixel by pixel
		start_frame();
		for (int ln = 0; ln < 4; ln++)
			send_random_line(12, view_ycbcr, 1'b1);
		wait_frame_drain();

		finish_run();
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
video_pkg.sv
video_delay.sv
rgb_to_ycbcr.sv
view_combiner.sv
video_color_top.sv
video_color_checker.sv
tb_video_color.sv

/* run_sim.sh */
#!/bin/sh
# Build the colour path testbench with Verilator, run it, pass only if the log holds the pass message

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_color -f sim.f -o tb_video_color > "$log" 2>&1 \
	&& ./obj_dir/tb_video_color +verilator+error+limit+100 >> "$log" 2>&1

cat "$log"

grep -q "SIMULATION PASSED" "$log" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail, see $log"; exit 1; }
